// ==== common/tdm_pkg.sv ====
// TDM multiplier shared constants, FSM encodings and operand/result structs
`default_nettype none

package tdm_pkg;

    // Q8.8 signed fixed point
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;
    localparam int PROD_W = 2 * DATA_W;

    // Lane count and index width
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;

    // One shift-add iteration per multiplier bit
    localparam int MUL_CYCLES = 16;
    localparam int MUL_CNT_W  = 4;

    // Largest positive Q8.8 value, used when clipping
    localparam logic [DATA_W-1:0] SAT_MAG = 16'h7fff;

    // Frame scheduler states
    localparam int             STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_W-1:0] ST_CALC = 2'd1;
    localparam logic [STATE_W-1:0] ST_DONE = 2'd2;

    // Multiplicand in the upper half, multiplier in the lower half
    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } operand_t;

    // Signed product with sticky clip flag
    typedef struct packed {
        logic [DATA_W-1:0] product;
        logic              overflow;
    } result_t;

endpackage

`default_nettype wire

// ==== fixed_mul/shift_add_core.sv ====
// Unsigned sequential shift-add multiplier, one multiplier bit per cycle
`timescale 1ns/1ps
`default_nettype none

module shift_add_core
    import tdm_pkg::*;
(
    input  wire               ctl_clk,
    input  wire               ctl_rst,
    input  wire               start,
    input  wire  [DATA_W-1:0] a,
    input  wire  [DATA_W-1:0] b,
    output logic              ready,
    output logic              done,
    output logic [PROD_W-1:0] product
);

    logic [MUL_CNT_W-1:0] count;
    logic                 running;
    logic                 load;
    logic                 last_step;
    logic [PROD_W-1:0]    mcand;
    logic [DATA_W-1:0]    mplier;

    assign load      = start && ready;
    assign last_step = running && (count == MUL_CNT_W'(MUL_CYCLES - 1));

    // Control: load cycle, then MUL_CYCLES iterations
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            running <= 1'b0;
            ready   <= 1'b1;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                running <= 1'b1;
                ready   <= 1'b0;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    ready   <= 1'b1;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Datapath, accumulator doubles as the product
    always_ff @(posedge ctl_clk) begin
        if (load) begin
            product <= '0;
            mcand   <= {{(PROD_W - DATA_W){1'b0}}, a};
            mplier  <= b;
        end else if (running) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== fixed_mul/fixed_mul.sv ====
// Signed Q8.8 multiplier wrapping the shift-add core with sign handling and clipping
`timescale 1ns/1ps
`default_nettype none

module fixed_mul
    import tdm_pkg::*;
(
    input  wire           ctl_clk,
    input  wire           ctl_rst,
    input  wire           mul_start,
    input  wire operand_t mul_operands,
    output logic          mul_ready,
    output logic          mul_done,
    output result_t       mul_result
);

    logic [DATA_W-1:0] mag_a;
    logic [DATA_W-1:0] mag_b;
    logic [PROD_W-1:0] product;
    logic [DATA_W-1:0] slice;
    logic [DATA_W-1:0] clipped;
    logic              overflow;
    logic              neg_q;

    // Two's complement magnitudes, -32768 maps to 0x8000
    assign mag_a = mul_operands.a[DATA_W-1] ? -mul_operands.a : mul_operands.a;
    assign mag_b = mul_operands.b[DATA_W-1] ? -mul_operands.b : mul_operands.b;

    // Result sign taken when the core accepts the operands
    always_ff @(posedge ctl_clk) begin
        if (mul_start && mul_ready) begin
            neg_q <= mul_operands.a[DATA_W-1] ^ mul_operands.b[DATA_W-1];
        end
    end

    shift_add_core u_core (
        .ctl_clk (ctl_clk),
        .ctl_rst (ctl_rst),
        .start   (mul_start),
        .a       (mag_a),
        .b       (mag_b),
        .ready   (mul_ready),
        .done    (mul_done),
        .product (product)
    );

    // Q16.16 product back to Q8.8
    assign slice = product[FRAC_W +: DATA_W];

    // Any integer bits above the slice, or a slice past the signed range
    assign overflow = (|product[PROD_W-1:FRAC_W+DATA_W]) || (slice > SAT_MAG);
    assign clipped  = overflow ? SAT_MAG : slice;

    always_comb begin
        mul_result.product  = neg_q ? -clipped : clipped;
        mul_result.overflow = overflow;
    end

endmodule

`default_nettype wire

// ==== source/lane_slot.sv ====
// Lane slot holding one captured operand pair and its latest product with overflow
`timescale 1ns/1ps
`default_nettype none

module lane_slot
    import tdm_pkg::*;
(
    input  wire           ctl_clk,
    input  wire           ctl_rst,
    input  wire           capture,
    input  wire           wr_en,
    input  wire operand_t operands_in,
    output operand_t      operands_held,
    input  wire result_t  result_in,
    output result_t       result
);

    // Operands frozen for the whole frame
    always_ff @(posedge ctl_clk) begin
        if (capture) begin
            operands_held <= operands_in;
        end
    end

    // Result only changes on this lane's write-back
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            result <= '0;
        end else if (wr_en) begin
            result <= result_in;
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_sched.sv ====
// Frame scheduler stepping the shared multiplier through every lane and strobing write-backs
`timescale 1ns/1ps
`default_nettype none

module frame_sched
    import tdm_pkg::*;
(
    input  wire                  ctl_clk,
    input  wire                  ctl_rst,
    input  wire                  frame_start,
    output logic                 busy,
    output logic                 frame_done,
    output logic                 capture,
    input  wire operand_t        lane_operands [NUM_LANES],
    output logic [NUM_LANES-1:0] wr_en,
    output operand_t             mul_operands,
    output logic                 mul_start,
    input  wire                  mul_ready,
    input  wire                  mul_done
);

    logic [STATE_W-1:0]    state;
    logic [LANE_IDX_W-1:0] lane_idx;
    logic                  in_flight;
    logic                  last_lane;

    assign busy       = (state == ST_CALC);
    assign frame_done = (state == ST_DONE);

    // Lanes latch their inputs on the accepting edge
    assign capture = frame_start && !busy;

    assign last_lane    = (lane_idx == LANE_IDX_W'(NUM_LANES - 1));
    assign mul_operands = lane_operands[lane_idx];

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_en[i] = busy && mul_done && (lane_idx == LANE_IDX_W'(i));
        end
    end

    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            state    <= ST_IDLE;
            lane_idx <= '0;
        end else begin
            case (state)
                ST_CALC: begin
                    if (mul_done) begin
                        if (last_lane) begin
                            state <= ST_DONE;
                        end else begin
                            lane_idx <= lane_idx + 1'b1;
                        end
                    end
                end
                ST_IDLE, ST_DONE: begin
                    // A new frame may start in the done cycle
                    if (capture) begin
                        state    <= ST_CALC;
                        lane_idx <= '0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // One start per lane, held off until that lane's done
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            mul_start <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            mul_start <= busy && mul_ready && !mul_start && !in_flight;
            if (mul_start) begin
                in_flight <= 1'b1;
            end else if (mul_done) begin
                in_flight <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tdm_mul_top.sv ====
// TDM multiplier top level joining the lane slots, frame scheduler and shared multiplier
`timescale 1ns/1ps
`default_nettype none

module tdm_mul_top
    import tdm_pkg::*;
(
    input  wire           ctl_clk,
    input  wire           ctl_rst,
    input  wire operand_t operands [NUM_LANES],
    input  wire           frame_start,
    output logic          busy,
    output logic          frame_done,
    output result_t       results [NUM_LANES]
);

    operand_t             lane_held [NUM_LANES];
    logic                 capture;
    logic [NUM_LANES-1:0] wr_en;

    // Shared multiplier handshake
    operand_t mul_operands;
    logic     mul_start;
    logic     mul_ready;
    logic     mul_done;
    result_t  mul_result;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_slot u_lane (
            .ctl_clk       (ctl_clk),
            .ctl_rst       (ctl_rst),
            .capture       (capture),
            .wr_en         (wr_en[i]),
            .operands_in   (operands[i]),
            .operands_held (lane_held[i]),
            .result_in     (mul_result),
            .result        (results[i])
        );
    end

    frame_sched u_sched (
        .ctl_clk       (ctl_clk),
        .ctl_rst       (ctl_rst),
        .frame_start   (frame_start),
        .busy          (busy),
        .frame_done    (frame_done),
        .capture       (capture),
        .lane_operands (lane_held),
        .wr_en         (wr_en),
        .mul_operands  (mul_operands),
        .mul_start     (mul_start),
        .mul_ready     (mul_ready),
        .mul_done      (mul_done)
    );

    fixed_mul u_mul (
        .ctl_clk      (ctl_clk),
        .ctl_rst      (ctl_rst),
        .mul_start    (mul_start),
        .mul_operands (mul_operands),
        .mul_ready    (mul_ready),
        .mul_done     (mul_done),
        .mul_result   (mul_result)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Testbench clock source with an active-low reset held for the first cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic ctl_clk,
    output logic ctl_rst
);

    localparam int HALF_PERIOD = 2;
    localparam int RST_CYCLES  = 16;

    // 4 ns period
    initial begin
        ctl_clk = 1'b0;
        forever begin
            #HALF_PERIOD ctl_clk = ~ctl_clk;
        end
    end

    initial begin
        ctl_rst = 1'b0;
        repeat (RST_CYCLES) @(posedge ctl_clk);
        #1 ctl_rst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_tdm_mul.sv ====
// TDM multiplier testbench driving random, clipping and overlapping frames against a reference
`timescale 1ns/1ps
`default_nettype none

module tb_tdm_mul
    import tdm_pkg::*;
();

    localparam int          FRAME_BOUND    = NUM_LANES * (MUL_CYCLES + 4) + 4;
    localparam int          TIMEOUT_CYCLES = 8 * FRAME_BOUND + 200;
    localparam int          NUM_FRAMES     = 6;
    localparam logic [31:0] SEED           = 32'h2168_5aba;

    logic     ctl_clk;
    logic     ctl_rst;
    operand_t operands [NUM_LANES];
    logic     frame_start;
    logic     busy;
    logic     frame_done;
    result_t  results [NUM_LANES];

    // Reference model state
    result_t  exp_res  [NUM_LANES];
    result_t  held_res [NUM_LANES];
    int       outstanding;
    int       frame_len;
    int       accepted       = 0;
    int       completed      = 0;
    int       ignored_starts = 0;
    int       ovf_frames     = 0;
    int       cycle_count    = 0;
    logic     rst_q          = 1'b0;
    logic     done_q         = 1'b0;
    logic     match_ok;
    logic     results_zero;
    logic     held_ok;
    logic     res_ovf_any;

    tb_clock_gen u_clk_gen (
        .ctl_clk (ctl_clk),
        .ctl_rst (ctl_rst)
    );

    tdm_mul_top uut (
        .ctl_clk     (ctl_clk),
        .ctl_rst     (ctl_rst),
        .operands    (operands),
        .frame_start (frame_start),
        .busy        (busy),
        .frame_done  (frame_done),
        .results     (results)
    );

    // Magnitude multiply, drop FRAC_W bits, clip, then apply the XOR sign
    function automatic result_t ref_mul(operand_t op);
        result_t r;
        longint  sa;
        longint  sb;
        longint  prod;
        logic    neg;
        sa   = longint'($signed(op.a));
        sb   = longint'($signed(op.b));
        neg  = op.a[DATA_W-1] ^ op.b[DATA_W-1];
        sa   = (sa < 0) ? -sa : sa;
        sb   = (sb < 0) ? -sb : sb;
        prod = (sa * sb) >> FRAC_W;
        r.overflow = (prod > longint'(SAT_MAG));
        if (r.overflow) begin
            prod = longint'(SAT_MAG);
        end
        r.product = neg ? DATA_W'(-prod) : DATA_W'(prod);
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] small_value();
        int v;
        v = int'($urandom % 32'd2049) - 1024;
        return DATA_W'(v);
    endfunction

    // At least 32.0 in size so any pair of these clips
    function automatic logic [DATA_W-1:0] large_value(input logic neg);
        int v;
        v = 32'h2000 + int'($urandom % 32'h6000);
        return neg ? DATA_W'(-v) : DATA_W'(v);
    endfunction

    task automatic fail_now(input string msg);
        $display("ERROR @ %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic next_edge();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic set_small_operands();
        for (int i = 0; i < NUM_LANES; i++) begin
            operands[i].a = small_value();
            operands[i].b = small_value();
        end
    endtask

    // Lane index picks the sign of a and b
    task automatic set_large_operands();
        for (int i = 0; i < NUM_LANES; i++) begin
            operands[i].a = large_value(i[0]);
            operands[i].b = large_value(i[1]);
        end
        operands[NUM_LANES-1].a = 16'h8000;
    endtask

    task automatic wait_frame_done();
        while (!frame_done) begin
            next_edge();
        end
    endtask

    task automatic run_frame();
        frame_start = 1'b1;
        next_edge();
        frame_start = 1'b0;
        wait_frame_done();
        next_edge();
    endtask

    always_comb begin
        match_ok     = 1'b1;
        results_zero = 1'b1;
        held_ok      = 1'b1;
        res_ovf_any  = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            match_ok     = match_ok && (results[i] == exp_res[i]);
            results_zero = results_zero && (results[i] == '0);
            held_ok      = held_ok && (results[i] == held_res[i]);
            res_ovf_any  = res_ovf_any || results[i].overflow;
        end
    end

    always @(posedge ctl_clk) begin
        rst_q  <= ctl_rst;
        done_q <= frame_done;
        if (!ctl_rst) begin
            outstanding <= 0;
            frame_len   <= 0;
            for (int i = 0; i < NUM_LANES; i++) begin
                exp_res[i]  <= '0;
                held_res[i] <= '0;
            end
        end else begin
            // Expected values fixed by the operands seen at acceptance
            if (frame_start && !busy) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    exp_res[i] <= ref_mul(operands[i]);
                end
                frame_len <= 0;
                accepted  <= accepted + 1;
            end else if (outstanding != 0) begin
                frame_len <= frame_len + 1;
            end
            if (frame_start && busy) begin
                ignored_starts <= ignored_starts + 1;
            end
            outstanding <= outstanding + int'(frame_start && !busy) - int'(frame_done);
            if (frame_done) begin
                held_res  <= results;
                completed <= completed + 1;
                if (res_ovf_any) begin
                    ovf_frames <= ovf_frames + 1;
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge ctl_clk)
        (ctl_rst && !rst_q) |-> (!busy && !frame_done && results_zero))
        else fail_now("busy, frame_done or results not clear after reset");
    a_results: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        frame_done |-> match_ok)
        else fail_now("lane results differ from reference at frame_done");
    a_one_done: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        frame_done |-> (outstanding == 1))
        else fail_now("frame_done without exactly one accepted start");
    a_busy_one: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        busy |-> (outstanding == 1))
        else fail_now("busy does not match the accepted frame count");
    a_done_pulse: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        frame_done |-> !done_q)
        else fail_now("frame_done held longer than one cycle");
    a_held: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        (!busy && !frame_done) |-> held_ok)
        else fail_now("results changed outside a frame");
    a_bound: assert property (@(posedge ctl_clk) disable iff (!ctl_rst)
        frame_done |-> (frame_len <= FRAME_BOUND))
        else fail_now("frame took longer than the frame bound");

    // Timeout
    always @(posedge ctl_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(SEED));
        frame_start = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            operands[i] = '0;
        end
        while (ctl_rst !== 1'b1) begin
            next_edge();
        end
        repeat (3) next_edge();

        // Random small values with a zero lane
        set_small_operands();
        operands[2].a = '0;
        run_frame();
        set_small_operands();
        run_frame();

        repeat (5) next_edge();
        set_large_operands();
        run_frame();

        // Operands change and starts arrive while busy
        set_small_operands();
        frame_start = 1'b1;
        next_edge();
        frame_start = 1'b0;
        for (int k = 0; k < 3; k++) begin
            repeat (7 + 5 * k) next_edge();
            set_large_operands();
            frame_start = 1'b1;
            next_edge();
            frame_start = 1'b0;
            set_small_operands();
        end
        wait_frame_done();

        // Next frame accepted in the frame_done cycle
        set_large_operands();
        frame_start = 1'b1;
        next_edge();
        frame_start = 1'b0;
        wait_frame_done();
        next_edge();

        repeat (10) next_edge();
        set_small_operands();
        run_frame();
        repeat (4) next_edge();

        if (completed == NUM_FRAMES && accepted == NUM_FRAMES && ignored_starts > 0
                && ovf_frames > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("End check: %0d accepted, %0d done, %0d ignored, %0d clipping frames",
                     accepted, completed, ignored_starts, ovf_frames);
            $display("Simulation FAILED");
            $fatal(1, "frame counts at the end of the run are wrong");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/tdm_pkg.sv
fixed_mul/shift_add_core.sv
fixed_mul/fixed_mul.sv
source/lane_slot.sv
source/frame_sched.sv
source/tdm_mul_top.sv
tests/tb_clock_gen.sv
tests/tb_tdm_mul.sv

// ==== Makefile ====
# Verilator build and run of the TDM multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_tdm_mul
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
EXTRA     ?=

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Testbench reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "No verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
